// File: mult_pkg.sv
`default_nettype none

package mult_pkg;

    // Operand and product sizes
    localparam int operand_width = 12;
    localparam int product_width = 24;

    // One partial-product row per multiplier bit
    localparam int pp_rows = operand_width;

    // Final adder is split into equal ripple blocks
    localparam int csel_block_width = 3;
    localparam int csel_blocks      = product_width / csel_block_width;

    typedef logic [operand_width-1:0]    operand_t;
    typedef logic [product_width-1:0]    product_t;
    typedef logic [csel_block_width-1:0] csel_block_t;

    // Input side handshake
    typedef enum logic [1:0] {
        cap_idle,
        cap_acked,
        cap_wait_release
    } capture_state_t;

    // Output side handshake
    typedef enum logic [1:0] {
        res_empty,
        res_offer,
        res_wait_release
    } result_state_t;

endpackage

`default_nettype wire

// File: operand_capture.sv
`default_nettype none

module operand_capture
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  operand_t a,
    input  operand_t b,
    input  logic     in_req,
    input  logic     result_busy,
    output logic     in_ack,
    output operand_t op_a,
    output operand_t op_b,
    output logic     op_valid
);

    capture_state_t state;
    logic           in_req_q;
    logic           take;

    // Request is registered once before the FSM looks at it
    always_ff @(posedge clk) begin
        if (reset) begin
            in_req_q <= 1'b0;
        end else begin
            in_req_q <= in_req;
        end
    end

    // New operands only when the output side has room
    assign take = (state == cap_idle) && in_req_q && !result_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cap_idle;
            in_ack   <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            op_valid <= 1'b0;
            case (state)
                cap_idle: begin
                    if (take) begin
                        in_ack   <= 1'b1;
                        op_valid <= 1'b1;
                        state    <= cap_acked;
                    end
                end
                cap_acked: begin
                    state <= cap_wait_release;
                end
                cap_wait_release: begin
                    // Source has let go of the request
                    if (!in_req_q) begin
                        in_ack <= 1'b0;
                        state  <= cap_idle;
                    end
                end
                default: begin
                    state <= cap_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_a <= a;
            op_b <= b;
        end
    end

endmodule

`default_nettype wire

// File: partial_product_gen.sv
`default_nettype none

module partial_product_gen
    import mult_pkg::*;
(
    input  operand_t op_a,
    input  operand_t op_b,
    output product_t pp_row [pp_rows]
);

    localparam int pad_width = product_width - operand_width;

    genvar i;

    generate
        for (i = 0; i < pp_rows; i++) begin : g_row
            operand_t gated;
            product_t padded;

            // AND of the multiplicand with one multiplier bit
            assign gated  = op_b & {operand_width{op_a[i]}};
            assign padded = {{pad_width{1'b0}}, gated};

            // Weight of bit i
            assign pp_row[i] = padded << i;
        end
    endgenerate

endmodule

`default_nettype wire

// File: csa_reduction_tree.sv
`default_nettype none

module csa_reduction_tree
    import mult_pkg::*;
(
    input  product_t pp_row [pp_rows],
    output product_t tree_sum,
    output product_t tree_carry
);

    // Carry vector of one 3:2 row, already moved to the next weight
    function automatic product_t csa_carry(
        input product_t x,
        input product_t y,
        input product_t z
    );
        product_t maj;
        maj = (x & y) | (y & z) | (x & z);
        return maj << 1;
    endfunction

    product_t lvl1 [8];
    product_t lvl2 [6];
    product_t lvl3 [4];
    product_t lvl4 [3];

    genvar g;

    // 12 rows to 8
    generate
        for (g = 0; g < 4; g++) begin : g_lvl1
            assign lvl1[2*g]   = pp_row[3*g] ^ pp_row[3*g+1] ^ pp_row[3*g+2];
            assign lvl1[2*g+1] = csa_carry(pp_row[3*g], pp_row[3*g+1], pp_row[3*g+2]);
        end
    endgenerate

    // 8 rows to 6, the last two pass through
    generate
        for (g = 0; g < 2; g++) begin : g_lvl2
            assign lvl2[2*g]   = lvl1[3*g] ^ lvl1[3*g+1] ^ lvl1[3*g+2];
            assign lvl2[2*g+1] = csa_carry(lvl1[3*g], lvl1[3*g+1], lvl1[3*g+2]);
        end
    endgenerate

    assign lvl2[4] = lvl1[6];
    assign lvl2[5] = lvl1[7];

    // 6 rows to 4
    generate
        for (g = 0; g < 2; g++) begin : g_lvl3
            assign lvl3[2*g]   = lvl2[3*g] ^ lvl2[3*g+1] ^ lvl2[3*g+2];
            assign lvl3[2*g+1] = csa_carry(lvl2[3*g], lvl2[3*g+1], lvl2[3*g+2]);
        end
    endgenerate

    // 4 rows to 3
    assign lvl4[0] = lvl3[0] ^ lvl3[1] ^ lvl3[2];
    assign lvl4[1] = csa_carry(lvl3[0], lvl3[1], lvl3[2]);
    assign lvl4[2] = lvl3[3];

    // Last row leaves the sum and carry pair for the final adder
    assign tree_sum   = lvl4[0] ^ lvl4[1] ^ lvl4[2];
    assign tree_carry = csa_carry(lvl4[0], lvl4[1], lvl4[2]);

endmodule

`default_nettype wire

// File: carry_select_adder.sv
`default_nettype none

module carry_select_adder
    import mult_pkg::*;
(
    input  product_t x,
    input  product_t y,
    output product_t sum
);

    // Ripple add of one block, carry out on top of the sum
    function automatic logic [csel_block_width:0] ripple(
        input csel_block_t p,
        input csel_block_t q,
        input logic        cin
    );
        csel_block_t s;
        logic        c;
        c = cin;
        for (int n = 0; n < csel_block_width; n++) begin
            s[n] = p[n] ^ q[n] ^ c;
            c    = (p[n] & q[n]) | (p[n] & c) | (q[n] & c);
        end
        return {c, s};
    endfunction

    // Carry into each upper block
    logic [csel_blocks-1:1] blk_cin;

    genvar k;

    generate
        for (k = 0; k < csel_blocks; k++) begin : g_blk
            localparam int lo = k * csel_block_width;

            logic [csel_block_width:0] res0;
            logic [csel_block_width:0] sel;

            // Both carry-in cases computed ahead of the real carry
            assign res0 = ripple(x[lo +: csel_block_width], y[lo +: csel_block_width], 1'b0);

            if (k == 0) begin : g_first
                // Lowest block only ever sees a zero carry-in
                assign sel = res0;
            end else begin : g_upper
                logic [csel_block_width:0] res1;

                assign res1 = ripple(x[lo +: csel_block_width], y[lo +: csel_block_width],
                                     1'b1);
                assign sel  = blk_cin[k] ? res1 : res0;
            end

            assign sum[lo +: csel_block_width] = sel[csel_block_width-1:0];

            // Top block carry falls off the 24-bit product
            if (k < csel_blocks - 1) begin : g_chain
                assign blk_cin[k+1] = sel[csel_block_width];
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: result_register.sv
`default_nettype none

module result_register
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     op_valid,
    input  product_t sum,
    input  logic     out_ack,
    output product_t product,
    output logic     out_req,
    output logic     result_busy
);

    result_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= res_empty;
            product     <= '0;
            out_req     <= 1'b0;
            result_busy <= 1'b0;
        end else begin
            case (state)
                res_empty: begin
                    // Adder output settles during the op_valid cycle
                    if (op_valid) begin
                        product     <= sum;
                        out_req     <= 1'b1;
                        result_busy <= 1'b1;
                        state       <= res_offer;
                    end
                end
                res_offer: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= res_wait_release;
                    end
                end
                res_wait_release: begin
                    // Transfer ends when the sink lets go
                    if (!out_ack) begin
                        result_busy <= 1'b0;
                        state       <= res_empty;
                    end
                end
                default: begin
                    out_req     <= 1'b0;
                    result_busy <= 1'b0;
                    state       <= res_empty;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: array_multiplier_top.sv
`default_nettype none

module array_multiplier_top
    import mult_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  operand_t a,
    input  operand_t b,
    input  logic     in_req,
    output logic     in_ack,
    output product_t product,
    output logic     out_req,
    input  logic     out_ack
);

    operand_t op_a;
    operand_t op_b;
    logic     op_valid;
    logic     result_busy;
    product_t pp_row [pp_rows];
    product_t tree_sum;
    product_t tree_carry;
    product_t sum;

    operand_capture u_capture (
        .clk         (clk),
        .reset       (reset),
        .a           (a),
        .b           (b),
        .in_req      (in_req),
        .result_busy (result_busy),
        .in_ack      (in_ack),
        .op_a        (op_a),
        .op_b        (op_b),
        .op_valid    (op_valid)
    );

    // Combinational datapath between the two registered sides
    partial_product_gen u_pp (
        .op_a   (op_a),
        .op_b   (op_b),
        .pp_row (pp_row)
    );

    csa_reduction_tree u_tree (
        .pp_row     (pp_row),
        .tree_sum   (tree_sum),
        .tree_carry (tree_carry)
    );

    carry_select_adder u_adder (
        .x   (tree_sum),
        .y   (tree_carry),
        .sum (sum)
    );

    result_register u_result (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .sum         (sum),
        .out_ack     (out_ack),
        .product     (product),
        .out_req     (out_req),
        .result_busy (result_busy)
    );

endmodule

`default_nettype wire

// File: tb_array_multiplier.sv
`default_nettype none

module tb_array_multiplier
    import mult_pkg::*;
();

    localparam int clk_period     = 20;
    localparam int total_txns     = 5 + 2 * operand_width + 300 + 4;
    localparam int cycles_per_txn = 20;
    localparam int hold_cycles    = 25;

    logic     clk;
    logic     reset;
    operand_t a;
    operand_t b;
    logic     in_req;
    logic     in_ack;
    product_t product;
    logic     out_req;
    logic     out_ack;

    integer   seed = 32'hae7a_6b23;
    operand_t exp_a [$];
    operand_t exp_b [$];
    int       sent_count      = 0;
    int       delivered_count = 0;
    int       value_errors    = 0;
    int       reset_errors    = 0;
    int       bp_errors       = 0;
    int       order_errors    = 0;
    int       bp_cycles       = 0;
    int       sink_hold       = 0;
    int       tests_passed    = 0;
    int       tests_failed    = 0;

    array_multiplier_top uut (
        .clk     (clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .product (product),
        .out_req (out_req),
        .out_ack (out_ack)
    );

    always #(clk_period / 2) clk = ~clk;

    // Shift-and-add over the bits of x
    function automatic product_t ref_product(input operand_t x, input operand_t y);
        product_t acc;
        acc = '0;
        for (int i = 0; i < operand_width; i++) begin
            if (x[i]) begin
                acc = acc + (product_t'(y) << i);
            end
        end
        return acc;
    endfunction

    task automatic send_pair(input operand_t x, input operand_t y);
        @(negedge clk);
        while (in_ack) @(negedge clk);
        @(posedge clk);
        a      <= x;
        b      <= y;
        in_req <= 1'b1;
        exp_a.push_back(x);
        exp_b.push_back(y);
        sent_count++;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        @(posedge clk);
        in_req <= 1'b0;
    endtask

    // Every request delivered and both handshakes back at rest
    task automatic drain();
        @(negedge clk);
        while (delivered_count != sent_count || out_ack || in_ack || out_req) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            $display("test %-16s ok", name);
            tests_passed++;
        end else begin
            $display("test %-16s FAILED with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // Sink answers out_req after a random or forced delay
    initial begin : sink
        int delay;
        forever begin
            @(negedge clk);
            if (!reset && out_req && !out_ack) begin
                if (sink_hold > 0) begin
                    delay = sink_hold;
                end else begin
                    delay = $unsigned($random(seed)) % 8;
                end
                repeat (delay) @(posedge clk);
                @(posedge clk);
                out_ack <= 1'b1;
                @(negedge clk);
                while (out_req) @(negedge clk);
                @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    end

    initial begin : compare
        operand_t ea;
        operand_t eb;
        product_t expected;
        forever begin
            @(negedge clk);
            if (!reset && out_req && out_ack) begin
                if (exp_a.size() == 0) begin
                    $display("[ERROR] t=%0t product %0d delivered with no request outstanding",
                             $time, product);
                    value_errors++;
                end else begin
                    ea       = exp_a.pop_front();
                    eb       = exp_b.pop_front();
                    expected = ref_product(ea, eb);
                    if (product !== expected) begin
                        $display("[ERROR] t=%0t a=%0d b=%0d expected %0d got %0d",
                                 $time, ea, eb, expected, product);
                        value_errors++;
                    end
                end
                delivered_count++;
            end
        end
    end

    // Handshake order and back-pressure monitor
    initial begin : monitor
        logic     in_req_prev;
        logic     in_ack_prev;
        logic     out_req_prev;
        logic     out_ack_prev;
        product_t product_prev;
        in_req_prev  = 1'b0;
        in_ack_prev  = 1'b0;
        out_req_prev = 1'b0;
        out_ack_prev = 1'b0;
        product_prev = '0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (in_ack_prev && !in_ack && in_req_prev) begin
                    $display("[ERROR] t=%0t in_ack fell while in_req was still high", $time);
                    order_errors++;
                end
                if (!in_ack_prev && in_ack && !in_req) begin
                    $display("[ERROR] t=%0t in_ack rose without a request", $time);
                    order_errors++;
                end
                if (!in_ack_prev && in_ack && (out_req_prev || out_ack_prev)) begin
                    $display("[ERROR] t=%0t in_ack rose while a result was still pending",
                             $time);
                    bp_errors++;
                end
                if (out_req_prev && out_req && product !== product_prev) begin
                    $display("[ERROR] t=%0t product changed from %0d to %0d while offered",
                             $time, product_prev, product);
                    bp_errors++;
                end
                if (in_req && out_req) begin
                    bp_cycles++;
                end
            end
            in_req_prev  = in_req;
            in_ack_prev  = in_ack;
            out_req_prev = out_req;
            out_ack_prev = out_ack;
            product_prev = product;
        end
    end

    initial begin : watchdog
        #(total_txns * cycles_per_txn * clk_period);
        $display("Run timed out after %0d time units with %0d of %0d products delivered",
                 $time, delivered_count, sent_count);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int start_errs;
        int bp_start;
        clk     = 1'b0;
        reset   = 1'b1;
        a       = '0;
        b       = '0;
        in_req  = 1'b0;
        out_ack = 1'b0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (in_ack !== 1'b0 || out_req !== 1'b0 || product !== '0) begin
            $display("[ERROR] t=%0t after reset in_ack=%b out_req=%b product=%0d",
                     $time, in_ack, out_req, product);
            reset_errors++;
        end
        report_test("reset", reset_errors);

        start_errs = value_errors;
        send_pair(12'd0, 12'd0);
        send_pair(12'd0, 12'd4095);
        send_pair(12'd1, 12'd4095);
        send_pair(12'd4095, 12'd1);
        send_pair(12'd4095, 12'd4095);
        drain();
        report_test("corners", value_errors - start_errs);

        // Powers of two against all ones walk carries through every block
        start_errs = value_errors;
        for (int k = 0; k < operand_width; k++) begin
            send_pair(12'd4095, operand_t'(1) << k);
        end
        for (int k = 0; k < operand_width; k++) begin
            send_pair(operand_t'(1) << k, 12'd4095);
        end
        drain();
        report_test("carry_chains", value_errors - start_errs);

        start_errs = value_errors;
        for (int n = 0; n < 300; n++) begin
            send_pair(operand_t'($random(seed)), operand_t'($random(seed)));
        end
        drain();
        report_test("random", value_errors - start_errs);

        // Sink withholds out_ack long enough for the next request to wait
        start_errs = value_errors;
        bp_start   = bp_cycles;
        sink_hold  = hold_cycles;
        for (int n = 0; n < 4; n++) begin
            send_pair(operand_t'(12'd3001 + n * 17), operand_t'(12'd2777 - n * 29));
        end
        drain();
        sink_hold = 0;
        if (bp_cycles == bp_start) begin
            $display("Back-pressure was never exercised, no request waited on a pending result");
            bp_errors++;
        end
        report_test("back_pressure", bp_errors + value_errors - start_errs);

        if (delivered_count != sent_count || exp_a.size() != 0) begin
            $display("Sent %0d requests but %0d products were delivered",
                     sent_count, delivered_count);
            order_errors++;
        end
        report_test("handshake_order", order_errors);

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: array_multiplier.f
mult_pkg.sv
operand_capture.sv
partial_product_gen.sv
csa_reduction_tree.sv
carry_select_adder.sv
result_register.sv
array_multiplier_top.sv
tb_array_multiplier.sv

// File: Bender.yml
package:
  name: array_multiplier

sources:
  - files:
      - mult_pkg.sv
      - operand_capture.sv
      - partial_product_gen.sv
      - csa_reduction_tree.sv
      - carry_select_adder.sv
      - result_register.sv
      - array_multiplier_top.sv
  - target: simulation
    files:
      - tb_array_multiplier.sv
